//--- common/adc_reg_pkg.sv
package adc_reg_pkg;

	////////////////////
	// SPI word fields

	typedef logic [6:0] reg_addr_t; // ADC register address
	typedef logic [7:0] reg_val_t;  // ADC register contents

	// One SPI transfer, MSB first on the wire
	typedef struct packed {
		logic      rw;    // Low for a write
		reg_addr_t addr;
		reg_val_t  value;
	} spi_word_t;

	localparam logic SPI_WRITE = 1'b0;

	////////////////////
	// Register map

	localparam reg_addr_t REG_SW_RESET = 7'h00; // Software reset
	localparam reg_addr_t REG_FORMAT   = 7'h01; // Output data format
	localparam reg_addr_t REG_LANES    = 7'h02; // Lane count select

	localparam reg_val_t VAL_SW_RESET  = 8'h80; // Self-clearing reset bit
	localparam reg_val_t VAL_TWOS_COMP = 8'h20; // Two's-complement samples
	localparam reg_val_t VAL_TWO_LANE  = 8'h00; // Two lanes per channel

	////////////////////
	// Host command pages

	// Upper byte of cmd_addr_in
	localparam logic [7:0] CMD_PAGE_REG_WRITE = 8'h31;

	////////////////////
	// Startup

	localparam int N_STARTUP_WORDS   = 3;
	localparam int INIT_WAIT_DEFAULT = 256; // Cycles after reset before first write

	// Written in this order once the wait ends
	localparam spi_word_t STARTUP_WORDS [0:N_STARTUP_WORDS-1] = '{
		'{rw: SPI_WRITE, addr: REG_SW_RESET, value: VAL_SW_RESET},
		'{rw: SPI_WRITE, addr: REG_FORMAT,   value: VAL_TWOS_COMP},
		'{rw: SPI_WRITE, addr: REG_LANES,    value: VAL_TWO_LANE}
	};

endpackage

//--- common/spi_timing_pkg.sv
package spi_timing_pkg;

	////////////////////
	// Frame shape

	// One write word per chip-select low period
	localparam int SPI_FRAME_BITS = 16;

	// Counts bits 0 to SPI_FRAME_BITS-1 within a frame
	typedef logic [4:0] bit_count_t;

	////////////////////
	// SPI clock

	// System cycles per SCK half-period
	// 5 gives 10 MHz SCK from a 100 MHz clk_in
	localparam int SPI_CLK_DIV_DEFAULT = 5;

	// Frame cost in system cycles, without the gap
	localparam int SPI_FRAME_CYCLES = 2 * SPI_CLK_DIV_DEFAULT * SPI_FRAME_BITS;

	// Sanity on the defaults
	localparam bit FRAME_FITS_COUNTER = (SPI_FRAME_BITS <= (1 << $bits(bit_count_t)));

	typedef logic [$clog2(SPI_FRAME_CYCLES + 1)-1:0] frame_cycle_t;

endpackage

//--- common/cfg_word_if.sv
interface cfg_word_if import adc_reg_pkg::*; ();

	logic      strobe; // One-cycle push or take
	spi_word_t word;   // Word being pushed or head of queue
	logic      full;   // Queue cannot accept a push
	logic      valid;  // Queue holds at least one word

	// Sequencer side
	// Pushes only while full is low
	modport producer (
		output strobe,
		output word,
		input  full
	);

	// SPI master side
	// Takes only while valid is high
	modport consumer (
		input  word,
		input  valid,
		output strobe
	);

endinterface

//--- sequencer/adc_startup_sequencer.sv
module adc_startup_sequencer import adc_reg_pkg::*; #(
	parameter int INIT_WAIT = INIT_WAIT_DEFAULT
) (
	input  logic        clk_in,
	input  logic        rst_in,

	input  logic        cmd_trig_in,
	input  logic [15:0] cmd_addr_in, // Page in [15:8], register in [6:0]
	input  logic [15:0] cmd_data_in, // Value in [7:0]

	cfg_word_if.producer word_out
);

	localparam int WAIT_W = $clog2(INIT_WAIT + 1);
	localparam int IDX_W  = $clog2(N_STARTUP_WORDS);

	localparam logic [WAIT_W-1:0] WAIT_LOAD = WAIT_W'(INIT_WAIT);
	localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(N_STARTUP_WORDS - 1);

	typedef enum logic [1:0] {
		ST_WAIT,    // Power-up delay
		ST_STARTUP, // Push the fixed register writes
		ST_CMD      // Serve host commands
	} seq_state_t;

	seq_state_t        state_q;
	logic [WAIT_W-1:0] wait_cnt_q; // Counts down to zero
	logic [IDX_W-1:0]  start_idx_q; // Next startup word
	logic              cmd_pend_q; // Decoded write waiting one cycle
	spi_word_t         cmd_word_q;
	logic              push;
	logic              page_hit;

	assign page_hit = cmd_addr_in[15:8] == CMD_PAGE_REG_WRITE;

	////////////////////
	// Push decision

	// Full is registered in the FIFO so no comb loop here
	always_comb begin
		push = 1'b0;
		case (state_q)
			ST_STARTUP: push = !word_out.full; // Hold word while full
			ST_CMD:     push = cmd_pend_q && !word_out.full; // Drop if full
			default:    push = 1'b0;
		endcase
	end

	assign word_out.strobe = push;
	assign word_out.word   = (state_q == ST_STARTUP) ? STARTUP_WORDS[start_idx_q]
	                                                 : cmd_word_q;

	////////////////////
	// Control FSM

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state_q     <= ST_WAIT;
			wait_cnt_q  <= WAIT_LOAD;
			start_idx_q <= '0;
			cmd_pend_q  <= 1'b0;
		end else begin
			cmd_pend_q <= 1'b0; // One-shot unless re-armed below
			case (state_q)
				ST_WAIT: begin
					if (wait_cnt_q == '0)
						state_q <= ST_STARTUP;
					else
						wait_cnt_q <= wait_cnt_q - 1'b1;
				end
				ST_STARTUP: begin
					if (push) begin
						start_idx_q <= start_idx_q + 1'b1;
						if (start_idx_q == IDX_LAST)
							state_q <= ST_CMD; // Last startup write queued
					end
				end
				ST_CMD: begin
					// Other pages ignored
					cmd_pend_q <= cmd_trig_in && page_hit;
				end
				default: state_q <= ST_WAIT;
			endcase
		end
	end

	// Command word payload
	always_ff @(posedge clk_in) begin
		if (cmd_trig_in) begin
			cmd_word_q.rw    <= SPI_WRITE;
			cmd_word_q.addr  <= cmd_addr_in[6:0];
			cmd_word_q.value <= cmd_data_in[7:0];
		end
	end

endmodule

//--- src/cfg_word_fifo.sv
module cfg_word_fifo import adc_reg_pkg::*; #(
	parameter int FIFO_DEPTH = 4 // Power of two, at least 2
) (
	input  logic clk_in,
	input  logic rst_in,

	cfg_word_if  wr, // Sequencer pushes here
	cfg_word_if  rd  // SPI master takes from here
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	localparam logic [PTR_W:0] COUNT_FULL = (PTR_W + 1)'(FIFO_DEPTH);

	spi_word_t        mem [FIFO_DEPTH]; // Storage
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0]   count_q; // Words held
	logic             push;
	logic             pop;
	logic             full;
	logic             valid;

	// Both sides already gated on the flow levels
	assign push = wr.strobe;
	assign pop  = rd.strobe;

	assign full  = count_q == COUNT_FULL;
	assign valid = count_q != '0;

	////////////////////
	// Flow levels

	assign wr.full  = full;
	assign rd.valid = valid;
	assign rd.word  = mem[rd_ptr_q]; // Show-ahead head word

	////////////////////
	// Pointers and count

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps at depth
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q; // Both or neither
			endcase
		end
	end

	// Storage write
	always_ff @(posedge clk_in) begin
		if (push)
			mem[wr_ptr_q] <= wr.word;
	end

endmodule

//--- spi_master/spi_frame_master.sv
module spi_frame_master import adc_reg_pkg::*, spi_timing_pkg::*; #(
	parameter int SPI_CLK_DIV = SPI_CLK_DIV_DEFAULT // Cycles per SCK half-period
) (
	input  logic clk_in,
	input  logic rst_in,

	cfg_word_if.consumer word_in,

	output logic spi_scs_out, // Active low
	output logic spi_sck_out, // Idles low, mode 0
	output logic spi_sdo_out
);

	localparam int DIV_W = $clog2(SPI_CLK_DIV + 1);

	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_CLK_DIV - 1);
	localparam bit_count_t       BIT_LAST = bit_count_t'(SPI_FRAME_BITS - 1);

	typedef enum logic [1:0] {
		M_IDLE,  // Chip select high, waiting for a word
		M_SHIFT, // Clocking out bits
		M_GAP    // Chip select high recovery time
	} master_state_t;

	master_state_t    state_q;
	spi_word_t        shift_q; // MSB is on SDO
	logic [DIV_W-1:0] div_cnt_q; // Half-period divider
	bit_count_t       bit_cnt_q;
	logic             scs_q;
	logic             sck_q;
	logic             sdo_q;
	logic             half_end;
	logic             take;

	assign half_end = div_cnt_q == DIV_LAST;
	assign take     = (state_q == M_IDLE) && word_in.valid;

	assign word_in.strobe = take; // Pop the head word

	assign spi_scs_out = scs_q;
	assign spi_sck_out = sck_q;
	assign spi_sdo_out = sdo_q;

	////////////////////
	// Frame sequencing

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state_q   <= M_IDLE;
			div_cnt_q <= '0;
			bit_cnt_q <= '0;
			scs_q     <= 1'b1;
			sck_q     <= 1'b0;
			sdo_q     <= 1'b0;
		end else begin
			div_cnt_q <= half_end ? '0 : div_cnt_q + 1'b1;
			case (state_q)
				M_IDLE: begin
					div_cnt_q <= '0;
					bit_cnt_q <= '0;
					if (take) begin
						state_q <= M_SHIFT;
						scs_q   <= 1'b0;
						sdo_q   <= word_in.word[SPI_FRAME_BITS-1]; // MSB ahead of first rise
					end
				end
				M_SHIFT: begin
					if (half_end) begin
						sck_q <= !sck_q;
						if (sck_q) begin // Falling SCK
							if (bit_cnt_q == BIT_LAST) begin
								state_q <= M_GAP;
								scs_q   <= 1'b1; // End of frame
								sdo_q   <= 1'b0;
							end else begin
								bit_cnt_q <= bit_cnt_q + 1'b1;
								sdo_q     <= shift_q[SPI_FRAME_BITS-2]; // Next bit
							end
						end
					end
				end
				M_GAP: begin
					if (half_end)
						state_q <= M_IDLE; // One half-period high
				end
				default: state_q <= M_IDLE;
			endcase
		end
	end

	// Shift register payload
	always_ff @(posedge clk_in) begin
		if (take)
			shift_q <= word_in.word;
		else if (state_q == M_SHIFT && half_end && sck_q)
			shift_q <= spi_word_t'({shift_q[SPI_FRAME_BITS-2:0], 1'b0});
	end

endmodule

//--- src/adc_cfg_top.sv
module adc_cfg_top import adc_reg_pkg::*, spi_timing_pkg::*; #(
	parameter int INIT_WAIT   = INIT_WAIT_DEFAULT,  // Startup delay in cycles
	parameter int FIFO_DEPTH  = 4,                  // Power of two
	parameter int SPI_CLK_DIV = SPI_CLK_DIV_DEFAULT // SCK half-period in cycles
) (
	input  logic        clk_in,
	input  logic        rst_in,

	// Host command port
	input  logic        cmd_trig_in,
	input  logic [15:0] cmd_addr_in,
	input  logic [15:0] cmd_data_in,

	// ADC SPI pins
	output logic        spi_scs_out,
	output logic        spi_sck_out,
	output logic        spi_sdo_out
);

	cfg_word_if seq_to_fifo (); // Sequencer into queue
	cfg_word_if fifo_to_spi (); // Queue head into SPI master

	////////////////////
	// Producer

	adc_startup_sequencer #(
		.INIT_WAIT   (INIT_WAIT)
	) u_sequencer (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.cmd_trig_in (cmd_trig_in),
		.cmd_addr_in (cmd_addr_in),
		.cmd_data_in (cmd_data_in),
		.word_out    (seq_to_fifo)
	);

	////////////////////
	// Buffer

	cfg_word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_in     (clk_in),
		.rst_in     (rst_in),
		.wr         (seq_to_fifo),
		.rd         (fifo_to_spi)
	);

	////////////////////
	// Consumer

	spi_frame_master #(
		.SPI_CLK_DIV (SPI_CLK_DIV)
	) u_spi_master (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.word_in     (fifo_to_spi),
		.spi_scs_out (spi_scs_out),
		.spi_sck_out (spi_sck_out),
		.spi_sdo_out (spi_sdo_out)
	);

endmodule

//--- verification/spi_frame_checker.sv
module spi_frame_checker (
	input logic clk_in,
	input logic rst_in,
	input logic spi_scs_out,
	input logic spi_sck_out,
	input logic spi_sdo_out
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////
	// SPI mode 0 rules

	// No clock outside a frame
	a_sck_idle: assert property (
		@(posedge clk_in) disable iff (rst_in)
		spi_scs_out |-> !spi_sck_out
	) else $error("SCK high while chip select is high");

	// Data only moves with SCK low
	a_sdo_stable: assert property (
		@(posedge clk_in) disable iff (rst_in)
		spi_sck_out |-> $stable(spi_sdo_out)
	) else $error("SDO changed while SCK is high");

	// Reset leaves the ADC deselected
	a_scs_reset: assert property (
		@(posedge clk_in)
		$past(rst_in) |-> spi_scs_out
	) else $error("Chip select low right after reset");

endmodule

bind spi_frame_master spi_frame_checker u_frame_checker (
	.clk_in      (clk_in),
	.rst_in      (rst_in),
	.spi_scs_out (spi_scs_out),
	.spi_sck_out (spi_sck_out),
	.spi_sdo_out (spi_sdo_out)
);

//--- verification/adc_cfg_tb.sv
module adc_cfg_tb import adc_reg_pkg::*, spi_timing_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SEED         = 6;
	localparam int RESET_CYCLES = 16;
	localparam int FIFO_DEPTH   = 4; // Matches the DUT default
	localparam int FRAME_LEN    = 2 * SPI_CLK_DIV_DEFAULT * (SPI_FRAME_BITS + 1); // Frame plus gap

	// Two startups with their frames and about twenty more frames, doubled
	localparam int TIMEOUT_CYCLES =
		2 * (2 * (RESET_CYCLES + INIT_WAIT_DEFAULT) + 20 * FRAME_LEN) + 2000;

	logic        clk_in = 1'b0;
	logic        rst_in;
	logic        cmd_trig_in;
	logic [15:0] cmd_addr_in;
	logic [15:0] cmd_data_in;
	logic        spi_scs_out;
	logic        spi_sck_out;
	logic        spi_sdo_out;

	spi_word_t   frame_q [$]; // Words seen on the SPI pins
	spi_word_t   exp_startup [3];
	logic [15:0] cap_shift;
	int          cap_bits     = 0;
	logic        prev_sck     = 1'b0;
	logic        prev_scs     = 1'b1;
	int          cycle_count  = 0;
	int          error_count  = 0;
	int          test_count   = 0;
	int          failed_count = 0;

	adc_cfg_top u_adc_cfg_top (.*);

	always #2 clk_in = !clk_in; // 4 ns period

	////////////////////
	// Frame capture

	// Pins are stable at the falling clk edge
	always @(negedge clk_in) begin
		if (!spi_scs_out && spi_sck_out && !prev_sck) begin // Rising SCK
			cap_shift = {cap_shift[14:0], spi_sdo_out};
			cap_bits++;
		end
		if (spi_scs_out && !prev_scs) begin // End of frame
			if (cap_bits == SPI_FRAME_BITS)
				frame_q.push_back(spi_word_t'(cap_shift));
			cap_bits = 0; // Cut frames dropped
		end
		prev_sck = spi_sck_out;
		prev_scs = spi_scs_out;
	end

	always @(posedge clk_in) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////
	// Compares

	task automatic check_word(input spi_word_t got, input spi_word_t exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s word %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
			error_count++;
		end
	endtask

	// Missing frames are reported by wait_frames
	task automatic check_next(input spi_word_t exp, input string what);
		if (frame_q.size() != 0)
			check_word(frame_q.pop_front(), exp, what);
	endtask

	task automatic check_no_frame(input string what);
		if (frame_q.size() != 0) begin
			$display("Unexpected frame %h during %s", frame_q[0], what);
			error_count++;
			frame_q.delete();
		end
	endtask

	////////////////////
	// Helpers

	// Returns on a rising clk, away from the capture
	task automatic wait_frames(input int n, input int limit, input string what);
		int waited;
		waited = 0;
		while (frame_q.size() < n && waited < limit) begin
			@(posedge clk_in);
			waited++;
		end
		if (frame_q.size() < n) begin
			$display("Missing frame: %0d of %0d %s frames after %0d cycles",
			         frame_q.size(), n, what, limit);
			error_count++;
		end
	endtask

	task automatic expect_quiet(input int cycles, input string what);
		repeat (cycles) @(posedge clk_in);
		check_no_frame(what);
	endtask

	// Called on a falling edge, leaves the trigger low
	task automatic send_cmd(input logic [7:0] page, input reg_addr_t addr, input reg_val_t val);
		cmd_trig_in = 1'b1;
		cmd_addr_in = {page, 1'($urandom), addr}; // Bit 7 is not decoded
		cmd_data_in = {8'($urandom), val};
		@(negedge clk_in);
		cmd_trig_in = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		if (error_count != errs_before) begin
			failed_count++;
			$display("%s: FAIL", name);
		end else
			$display("%s: ok", name);
	endtask

	////////////////////
	// Tests

	task automatic test_reset_levels();
		int errs;
		errs = error_count;
		repeat (RESET_CYCLES) begin
			@(negedge clk_in);
			check_level(spi_scs_out, 1'b1, "scs in reset");
			check_level(spi_sck_out, 1'b0, "sck in reset");
			check_level(spi_sdo_out, 1'b0, "sdo in reset");
		end
		rst_in = 1'b0;
		for (int i = 0; i < INIT_WAIT_DEFAULT; i++) begin
			if (i == INIT_WAIT_DEFAULT / 2)
				send_cmd(CMD_PAGE_REG_WRITE, 7'h55, 8'hAA); // Early command, ignored
			else
				@(negedge clk_in);
			check_level(spi_scs_out, 1'b1, "scs in startup wait");
			check_level(spi_sck_out, 1'b0, "sck in startup wait");
			check_level(spi_sdo_out, 1'b0, "sdo in startup wait");
		end
		finish_test("reset_levels", errs);
	endtask

	task automatic test_startup_sequence();
		int errs;
		errs = error_count;
		wait_frames(3, 6 * FRAME_LEN, "startup");
		for (int i = 0; i < 3; i++)
			check_next(exp_startup[i], "startup");
		expect_quiet(2 * FRAME_LEN, "after startup");
		finish_test("startup_sequence", errs);
	endtask

	task automatic test_register_write();
		int        errs;
		reg_addr_t addr;
		reg_val_t  val;
		errs = error_count;
		repeat (3) begin
			@(negedge clk_in);
			addr = 7'($urandom);
			val  = 8'($urandom);
			send_cmd(CMD_PAGE_REG_WRITE, addr, val);
			wait_frames(1, 3 * FRAME_LEN, "command");
			check_next(spi_word_t'({1'b0, addr, val}), "command");
		end
		finish_test("register_write", errs);
	endtask

	task automatic test_ignored_pages();
		int errs;
		errs = error_count;
		@(negedge clk_in);
		send_cmd(8'h32, 7'h11, 8'h22); // Dropped phase-shift page
		send_cmd(8'h30, 7'h33, 8'h44);
		expect_quiet(2 * FRAME_LEN, "ignored pages");
		finish_test("ignored_pages", errs);
	endtask

	task automatic test_queued_burst();
		int        errs;
		spi_word_t sent [$];
		reg_addr_t addr;
		reg_val_t  val;
		errs = error_count;
		@(negedge clk_in);
		for (int i = 0; i < FIFO_DEPTH; i++) begin // Back-to-back strobes
			addr = 7'($urandom);
			val  = 8'($urandom);
			sent.push_back(spi_word_t'({1'b0, addr, val}));
			cmd_trig_in = 1'b1;
			cmd_addr_in = {CMD_PAGE_REG_WRITE, 1'b0, addr};
			cmd_data_in = {8'h00, val};
			@(negedge clk_in);
		end
		cmd_trig_in = 1'b0;
		wait_frames(FIFO_DEPTH, (FIFO_DEPTH + 2) * FRAME_LEN, "burst");
		foreach (sent[i])
			check_next(sent[i], "burst");
		expect_quiet(2 * FRAME_LEN, "after burst");
		finish_test("queued_burst", errs);
	endtask

	task automatic test_reset_mid_frame();
		int errs;
		int waited;
		errs   = error_count;
		waited = 0;
		@(negedge clk_in);
		send_cmd(CMD_PAGE_REG_WRITE, 7'($urandom), 8'($urandom));
		while (spi_scs_out && waited < 4 * FRAME_LEN) begin
			@(negedge clk_in);
			waited++;
		end
		if (spi_scs_out) begin
			$display("No frame started before the mid-frame reset");
			error_count++;
		end
		repeat (8 * SPI_CLK_DIV_DEFAULT) @(negedge clk_in); // About four bits in
		rst_in = 1'b1;
		#1;
		check_level(spi_scs_out, 1'b1, "scs at reset");
		check_level(spi_sck_out, 1'b0, "sck at reset");
		repeat (RESET_CYCLES) @(negedge clk_in);
		frame_q.delete();
		rst_in = 1'b0;
		wait_frames(3, INIT_WAIT_DEFAULT + 6 * FRAME_LEN, "restart");
		for (int i = 0; i < 3; i++)
			check_next(exp_startup[i], "restart");
		expect_quiet(2 * FRAME_LEN, "after restart");
		finish_test("reset_mid_frame", errs);
	endtask

	initial begin
		void'($urandom(SEED));
		rst_in      = 1'b1;
		cmd_trig_in = 1'b0;
		cmd_addr_in = '0;
		cmd_data_in = '0;
		// Write, register, value
		exp_startup[0] = spi_word_t'({1'b0, 7'h00, 8'h80});
		exp_startup[1] = spi_word_t'({1'b0, 7'h01, 8'h20});
		exp_startup[2] = spi_word_t'({1'b0, 7'h02, 8'h00});
		test_reset_levels();
		test_startup_sequence();
		test_register_write();
		test_ignored_pages();
		test_queued_burst();
		test_reset_mid_frame();
		$display("tests run %0d, failing tests %0d, errors %0d",
		         test_count, failed_count, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- build.f
common/adc_reg_pkg.sv
common/spi_timing_pkg.sv
common/cfg_word_if.sv
sequencer/adc_startup_sequencer.sv
src/cfg_word_fifo.sv
spi_master/spi_frame_master.sv
src/adc_cfg_top.sv
verification/spi_frame_checker.sv
verification/adc_cfg_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module adc_cfg_tb -o sim_adc_cfg

./obj_dir/sim_adc_cfg > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0
